// File: sim.f
+incdir+include
logic/im2col_cfg_pkg.sv
logic/im2col_desc_pkg.sv
logic/im2col_seq_fsm.sv
logic/im2col_loop_counters.sv
logic/im2col_pad_zeros.sv
logic/im2col_src_addr.sv
logic/im2col_param_gen.sv
verif/im2col_param_gen_props.sv
verif/im2col_param_gen_tb.sv

// File: Bender.yml
package:
  name: im2col_param_gen

sources:
  - include_dirs:
      - include
    files:
      - logic/im2col_cfg_pkg.sv
      - logic/im2col_desc_pkg.sv
      - logic/im2col_seq_fsm.sv
      - logic/im2col_loop_counters.sv
      - logic/im2col_pad_zeros.sv
      - logic/im2col_src_addr.sv
      - logic/im2col_param_gen.sv
  - target: simulation
    files:
      - verif/im2col_param_gen_props.sv
      - verif/im2col_param_gen_tb.sv

// File: verif/im2col_param_gen_tb.sv
// testbench for the im2col descriptor generator that checks random configurations against a model
`timescale 1ns/1ns
`default_nettype none

module im2col_param_gen_tb;

  logic clk_i;
  logic rst_ni;
  logic start_i;
  logic fifo_full_i;
  logic fifo_push_o;
  logic param_done_o;
  im2col_cfg_pkg::im2col_cfg_t cfg_i;
  im2col_desc_pkg::dma_desc_t desc_o;

  im2col_cfg_pkg::im2col_cfg_t cfg;
  im2col_desc_pkg::dma_desc_t exp_q[$];
  integer seed;
  int errors;
  int tests_pass;
  int tests_fail;
  bit timed_out;

  im2col_param_gen dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_i       (cfg_i),
    .start_i     (start_i),
    .fifo_full_i (fifo_full_i),
    .fifo_push_o (fifo_push_o),
    .desc_o      (desc_o),
    .param_done_o(param_done_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // pad_mode 0 is no padding, 1 is any pad below the filter size, 2 forces nonzero pads
  task automatic draw_cfg(input int pad_mode, input int batch_fix);
    cfg.fh = 8'((pad_mode == 2) ? 2 + rand_below(2) : 1 + rand_below(3));
    cfg.fw = 8'((pad_mode == 2) ? 2 + rand_below(2) : 1 + rand_below(3));
    cfg.num_ch = 8'(1 + rand_below(2));
    cfg.batch = 8'((batch_fix > 0) ? batch_fix : 1 + rand_below(2));
    cfg.pad_left = 8'((pad_mode == 0) ? 0 : (pad_mode == 1) ? rand_below(int'(cfg.fw))
                      : 1 + rand_below(int'(cfg.fw) - 1));
    cfg.adpt_pad_right = 8'((pad_mode == 0) ? 0 : (pad_mode == 1) ? rand_below(int'(cfg.fw))
                            : 1 + rand_below(int'(cfg.fw) - 1));
    cfg.pad_top = 8'((pad_mode == 0) ? 0 : (pad_mode == 1) ? rand_below(int'(cfg.fh))
                     : 1 + rand_below(int'(cfg.fh) - 1));
    cfg.adpt_pad_bottom = 8'((pad_mode == 0) ? 0 : (pad_mode == 1) ? rand_below(int'(cfg.fh))
                             : 1 + rand_below(int'(cfg.fh) - 1));
    cfg.ih = 16'(4 + rand_below(5));
    cfg.iw = 16'(4 + rand_below(5));
    // pads stay below 3, so 4 patches always cover both pads of one side
    cfg.n_patches_w = 16'(4 + rand_below(5));
    cfg.n_patches_h = 16'(4 + rand_below(5));
    cfg.ch_col = 16'(int'(cfg.num_ch) * int'(cfg.fh) * int'(cfg.fw));
    cfg.src_ptr = $random(seed);
    cfg.dst_ptr = $random(seed);
  endtask

  // channel, filter row, filter column outside, batch innermost
  task automatic build_expected();
    int c;
    int h;
    int w;
    int b;
    int k;
    int left;
    int right;
    int top;
    int bottom;
    int idx;
    im2col_desc_pkg::dma_desc_t d;
    exp_q.delete();
    k = 0;
    for (c = 0; c < int'(cfg.num_ch); c++) begin
      for (h = 0; h < int'(cfg.fh); h++) begin
        for (w = 0; w < int'(cfg.fw); w++) begin
          for (b = 0; b < int'(cfg.batch); b++) begin
            left = (int'(cfg.pad_left) > w) ? int'(cfg.pad_left) - w : 0;
            top = (int'(cfg.pad_top) > h) ? int'(cfg.pad_top) - h : 0;
            right = int'(cfg.adpt_pad_right) - (int'(cfg.fw) - 1 - w);
            right = (right > 0) ? right : 0;
            bottom = int'(cfg.adpt_pad_bottom) - (int'(cfg.fh) - 1 - h);
            bottom = (bottom > 0) ? bottom : 0;
            idx = ((b * int'(cfg.num_ch) + c) * int'(cfg.ih) + h - int'(cfg.pad_top) + top)
                  * int'(cfg.iw) + w - int'(cfg.pad_left) + left;
            d.n_zeros_left = 8'(left);
            d.n_zeros_right = 8'(right);
            d.n_zeros_top = 8'(top);
            d.n_zeros_bottom = 8'(bottom);
            d.size_d1 = 16'(int'(cfg.n_patches_w) - left - right);
            d.size_d2 = 16'(int'(cfg.n_patches_h) - top - bottom);
            d.input_ptr = cfg.src_ptr + 32'(4 * idx);
            d.output_ptr = cfg.dst_ptr
                           + 32'(4 * k * int'(cfg.n_patches_h) * int'(cfg.n_patches_w));
            d.in_inc_d2 = 23'(int'(cfg.iw) - int'(d.size_d1) + 1);
            exp_q.push_back(d);
            k++;
          end
        end
      end
    end
  endtask

  task automatic run_config(input string name, input int pad_mode, input int batch_fix,
                            input bit bp, input bit step_chk);
    int errs_before;
    int n_exp;
    int n_got;
    int wait_cnt;
    logic [31:0] step;
    im2col_desc_pkg::dma_desc_t exp_d;
    im2col_desc_pkg::dma_desc_t prev_d;
    if (timed_out) return;
    errs_before = errors;
    draw_cfg(pad_mode, batch_fix);
    build_expected();
    n_exp = exp_q.size();
    step = 32'(4 * int'(cfg.n_patches_h) * int'(cfg.n_patches_w));
    @(negedge clk_i);
    cfg_i = cfg;
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    assert (!param_done_o) else begin
      $display("param_done_o did not fall after start in %s", name);
      errors++;
    end
    n_got = 0;
    wait_cnt = 0;
    while (n_got < n_exp && wait_cnt < 2000 && !param_done_o) begin
      @(negedge clk_i);
      fifo_full_i = bp && (rand_below(10) < 3);
      #1;
      wait_cnt++;
      if (fifo_push_o) begin
        exp_d = exp_q.pop_front();
        check_field("input_ptr", desc_o.input_ptr, exp_d.input_ptr);
        check_field("output_ptr", desc_o.output_ptr, exp_d.output_ptr);
        check_field("in_inc_d2", 32'(desc_o.in_inc_d2), 32'(exp_d.in_inc_d2));
        check_field("n_zeros_top", 32'(desc_o.n_zeros_top), 32'(exp_d.n_zeros_top));
        check_field("n_zeros_bottom", 32'(desc_o.n_zeros_bottom), 32'(exp_d.n_zeros_bottom));
        check_field("n_zeros_left", 32'(desc_o.n_zeros_left), 32'(exp_d.n_zeros_left));
        check_field("n_zeros_right", 32'(desc_o.n_zeros_right), 32'(exp_d.n_zeros_right));
        check_field("size_d1", 32'(desc_o.size_d1), 32'(exp_d.size_d1));
        check_field("size_d2", 32'(desc_o.size_d2), 32'(exp_d.size_d2));
        if (step_chk && n_got > 0) begin
          check_field("output_ptr_step", desc_o.output_ptr - prev_d.output_ptr, step);
          // odd pushes are batch 1 of the same filter position
          assert ((n_got % 2 == 0) || (desc_o.input_ptr != prev_d.input_ptr)) else begin
            $display("input pointer unchanged across the batch step in %s", name);
            errors++;
          end
        end
        prev_d = desc_o;
        n_got++;
        wait_cnt = 0;
      end
    end
    fifo_full_i = 1'b0;
    if (n_got < n_exp) begin
      if (param_done_o) begin
        $display("param_done_o rose after %0d of %0d pushes in %s", n_got, n_exp, name);
        errors++;
      end else begin
        $display("timeout waiting for push %0d of %0d in %s", n_got + 1, n_exp, name);
        errors++;
        timed_out = 1'b1;
      end
    end
    wait_cnt = 0;
    while (!param_done_o && wait_cnt < 2000 && !timed_out) begin
      @(negedge clk_i);
      wait_cnt++;
      assert (!fifo_push_o) else begin
        $display("push beyond the expected %0d descriptors in %s", n_exp, name);
        errors++;
      end
    end
    if (!param_done_o && !timed_out) begin
      $display("timeout waiting for param_done_o in %s", name);
      errors++;
      timed_out = 1'b1;
    end
    // the generator must stay idle with done held
    repeat (20) begin
      @(negedge clk_i);
      fifo_full_i = bp && (rand_below(10) < 3);
      #1;
      assert (!fifo_push_o && param_done_o) else begin
        $display("push after done or done dropped while idle in %s", name);
        errors++;
      end
    end
    fifo_full_i = 1'b0;
    if (errors == errs_before) begin
      tests_pass++;
      $display("test %s: %0d descriptors ok", name, n_got);
    end else begin
      tests_fail++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  initial begin
    int i;
    seed = 32'h864b_0be3;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    start_i = 1'b0;
    fifo_full_i = 1'b0;
    cfg_i = '0;
    cfg = '0;
    errors = 0;
    tests_pass = 0;
    tests_fail = 0;
    timed_out = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    assert (!fifo_push_o && !param_done_o) else begin
      $display("push or done high after reset");
      errors++;
    end
    run_config("zero_pad_batch1", 0, 1, 1'b0, 1'b0);
    run_config("nonzero_pads", 2, 0, 1'b0, 1'b0);
    run_config("back_pressure", 1, 0, 1'b1, 1'b0);
    run_config("batch2_step", 1, 2, 1'b1, 1'b1);
    run_config("done_restart_a", 2, 2, 1'b1, 1'b1);
    run_config("done_restart_b", 1, 0, 1'b1, 1'b0);
    for (i = 0; i < 4; i++) begin
      run_config($sformatf("random_%0d", i), 1, 0, 1'b1, 1'b0);
    end
    if (dut.u_props.fail_cnt != 0) begin
      $display("%0d handshake assertion failures in the bound checker", dut.u_props.fail_cnt);
    end
    $display("tests passed %0d failed %0d", tests_pass, tests_fail);
    if (errors == 0 && tests_fail == 0 && !timed_out && dut.u_props.fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/im2col_param_gen_props.sv
// handshake checks bound into the im2col descriptor generator top level during simulation
`timescale 1ns/1ns
`default_nettype none

module im2col_param_gen_props (
  input logic clk_i,
  input logic rst_ni,
  input logic fifo_full_i,
  input logic fifo_push_i,
  input logic param_done_i
);

  int fail_cnt = 0;

  // a push into a full FIFO would lose the descriptor
  no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fifo_push_i |-> !fifo_full_i)
    else begin
      $error("descriptor pushed while the FIFO is full");
      fail_cnt++;
    end

  single_cycle_push: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fifo_push_i |=> !fifo_push_i)
    else begin
      $error("push held for more than one cycle");
      fail_cnt++;
    end

  no_push_when_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fifo_push_i |-> !param_done_i)
    else begin
      $error("descriptor pushed while done is high");
      fail_cnt++;
    end

endmodule

bind im2col_param_gen im2col_param_gen_props u_props (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .fifo_full_i (fifo_full_i),
  .fifo_push_i (fifo_push_o),
  .param_done_i(param_done_o)
);

`default_nettype wire

// File: logic/im2col_param_gen.sv
// top level of the im2col descriptor generator, emits one DMA descriptor per FIFO push
`timescale 1ns/1ns
`default_nettype none

module im2col_param_gen (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  im2col_cfg_pkg::im2col_cfg_t cfg_i,
  input  logic                        start_i,
  input  logic                        fifo_full_i,
  output logic                        fifo_push_o,
  output im2col_desc_pkg::dma_desc_t  desc_o,
  output logic                        param_done_o
);

  logic cnt_clear;
  logic batch_inc;
  logic batch_clear;
  logic pos_step;
  logic zeros_clear;
  logic zeros_ph1;
  logic zeros_ph2;
  logic out_ptr_clear;
  logic out_ptr_step;
  logic pipe_clear;
  logic batch_last;
  logic pos_last;

  im2col_cfg_pkg::dim_t w_offset;
  im2col_cfg_pkg::dim_t h_offset;
  im2col_cfg_pkg::dim_t im_c;
  im2col_cfg_pkg::dim_t batch_cnt;
  im2col_cfg_pkg::dim_t n_zeros_left;
  im2col_cfg_pkg::dim_t n_zeros_right;
  im2col_cfg_pkg::dim_t n_zeros_top;
  im2col_cfg_pkg::dim_t n_zeros_bottom;
  im2col_desc_pkg::xfer_size_t size_d1;
  im2col_desc_pkg::xfer_size_t size_d2;
  im2col_desc_pkg::ptr_t input_ptr;
  im2col_desc_pkg::ptr_t output_ptr;
  im2col_desc_pkg::inc_t in_inc_d2;

  im2col_seq_fsm u_seq (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .fifo_full_i    (fifo_full_i),
    .batch_last_i   (batch_last),
    .pos_last_i     (pos_last),
    .fifo_push_o    (fifo_push_o),
    .param_done_o   (param_done_o),
    .cnt_clear_o    (cnt_clear),
    .batch_inc_o    (batch_inc),
    .batch_clear_o  (batch_clear),
    .pos_step_o     (pos_step),
    .zeros_clear_o  (zeros_clear),
    .zeros_ph1_o    (zeros_ph1),
    .zeros_ph2_o    (zeros_ph2),
    .out_ptr_clear_o(out_ptr_clear),
    .out_ptr_step_o (out_ptr_step),
    .pipe_clear_o   (pipe_clear)
  );

  im2col_loop_counters u_cnt (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_i        (cfg_i),
    .cnt_clear_i  (cnt_clear),
    .batch_inc_i  (batch_inc),
    .batch_clear_i(batch_clear),
    .pos_step_i   (pos_step),
    .w_offset_o   (w_offset),
    .h_offset_o   (h_offset),
    .im_c_o       (im_c),
    .batch_cnt_o  (batch_cnt),
    .batch_last_o (batch_last),
    .pos_last_o   (pos_last)
  );

  im2col_pad_zeros u_zeros (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cfg_i           (cfg_i),
    .w_offset_i      (w_offset),
    .h_offset_i      (h_offset),
    .zeros_clear_i   (zeros_clear),
    .zeros_ph1_i     (zeros_ph1),
    .zeros_ph2_i     (zeros_ph2),
    .n_zeros_left_o  (n_zeros_left),
    .n_zeros_right_o (n_zeros_right),
    .n_zeros_top_o   (n_zeros_top),
    .n_zeros_bottom_o(n_zeros_bottom),
    .size_d1_o       (size_d1),
    .size_d2_o       (size_d2)
  );

  im2col_src_addr u_addr (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cfg_i          (cfg_i),
    .w_offset_i     (w_offset),
    .h_offset_i     (h_offset),
    .im_c_i         (im_c),
    .batch_cnt_i    (batch_cnt),
    .n_zeros_left_i (n_zeros_left),
    .n_zeros_top_i  (n_zeros_top),
    .size_d1_i      (size_d1),
    .pipe_clear_i   (pipe_clear),
    .out_ptr_clear_i(out_ptr_clear),
    .out_ptr_step_i (out_ptr_step),
    .input_ptr_o    (input_ptr),
    .output_ptr_o   (output_ptr),
    .in_inc_d2_o    (in_inc_d2)
  );

  // fields are stable from INDEX_3 through the push
  assign desc_o.input_ptr      = input_ptr;
  assign desc_o.output_ptr     = output_ptr;
  assign desc_o.in_inc_d2      = in_inc_d2;
  assign desc_o.n_zeros_top    = n_zeros_top;
  assign desc_o.n_zeros_bottom = n_zeros_bottom;
  assign desc_o.n_zeros_left   = n_zeros_left;
  assign desc_o.n_zeros_right  = n_zeros_right;
  assign desc_o.size_d1        = size_d1;
  assign desc_o.size_d2        = size_d2;

endmodule

`default_nettype wire

// File: logic/im2col_src_addr.sv
// address unit of the im2col descriptor generator, pipelined source index and pointers
`timescale 1ns/1ns
`default_nettype none

module im2col_src_addr (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  im2col_cfg_pkg::im2col_cfg_t cfg_i,
  input  im2col_cfg_pkg::dim_t        w_offset_i,
  input  im2col_cfg_pkg::dim_t        h_offset_i,
  input  im2col_cfg_pkg::dim_t        im_c_i,
  input  im2col_cfg_pkg::dim_t        batch_cnt_i,
  input  im2col_cfg_pkg::dim_t        n_zeros_left_i,
  input  im2col_cfg_pkg::dim_t        n_zeros_top_i,
  input  im2col_desc_pkg::xfer_size_t size_d1_i,
  input  logic                        pipe_clear_i,
  input  logic                        out_ptr_clear_i,
  input  logic                        out_ptr_step_i,
  output im2col_desc_pkg::ptr_t       input_ptr_o,
  output im2col_desc_pkg::ptr_t       output_ptr_o,
  output im2col_desc_pkg::inc_t       in_inc_d2_o
);

  im2col_cfg_pkg::idx_t stage1_q;
  im2col_cfg_pkg::idx_t stage2_q;
  im2col_cfg_pkg::idx_t stage3_q;
  im2col_cfg_pkg::idx_t plane_idx;
  im2col_cfg_pkg::idx_t row_idx;
  im2col_cfg_pkg::idx_t col_idx;
  im2col_cfg_pkg::idx_t index;
  im2col_desc_pkg::ptr_t out_ptr_q;
  im2col_desc_pkg::ptr_t out_step;

  // image plane selected by batch and channel
  assign plane_idx = im2col_cfg_pkg::idx_t'(batch_cnt_i) * im2col_cfg_pkg::idx_t'(cfg_i.num_ch)
                     + im2col_cfg_pkg::idx_t'(im_c_i);

  // first row read, top zeros skip the padded rows above the image
  assign row_idx = stage2_q + im2col_cfg_pkg::idx_t'(h_offset_i)
                   + im2col_cfg_pkg::idx_t'(n_zeros_top_i)
                   - im2col_cfg_pkg::idx_t'(cfg_i.pad_top);

  assign col_idx = im2col_cfg_pkg::idx_t'(w_offset_i) + im2col_cfg_pkg::idx_t'(n_zeros_left_i)
                   - im2col_cfg_pkg::idx_t'(cfg_i.pad_left);

  // free running, stages settle one after another once the counters hold still
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage1_q <= '0;
      stage2_q <= '0;
      stage3_q <= '0;
    end else if (pipe_clear_i) begin
      stage1_q <= '0;
      stage2_q <= '0;
      stage3_q <= '0;
    end else begin
      stage1_q <= plane_idx;
      stage2_q <= stage1_q * im2col_cfg_pkg::idx_t'(cfg_i.ih);
      stage3_q <= row_idx * im2col_cfg_pkg::idx_t'(cfg_i.iw);
    end
  end

  assign index = stage3_q + col_idx;

  // 32-bit elements, hence the shift by two
  assign input_ptr_o = cfg_i.src_ptr + (index << 2);

  // jump from the end of one row to the start of the next
  assign in_inc_d2_o = im2col_desc_pkg::inc_t'(cfg_i.iw) - im2col_desc_pkg::inc_t'(size_d1_i)
                       + 1'b1;

  // one full output patch per descriptor
  assign out_step = (im2col_desc_pkg::ptr_t'(cfg_i.n_patches_h)
                     * im2col_desc_pkg::ptr_t'(cfg_i.n_patches_w)) << 2;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ptr_q <= '0;
    end else if (out_ptr_clear_i) begin
      out_ptr_q <= cfg_i.dst_ptr;
    end else if (out_ptr_step_i) begin
      out_ptr_q <= out_ptr_q + out_step;
    end
  end

  assign output_ptr_o = out_ptr_q;

endmodule

`default_nettype wire

// File: logic/im2col_pad_zeros.sv
// zero padding unit of the im2col descriptor generator, two phases per filter position
`timescale 1ns/1ns
`default_nettype none

module im2col_pad_zeros (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  im2col_cfg_pkg::im2col_cfg_t cfg_i,
  input  im2col_cfg_pkg::dim_t        w_offset_i,
  input  im2col_cfg_pkg::dim_t        h_offset_i,
  input  logic                        zeros_clear_i,
  input  logic                        zeros_ph1_i,
  input  logic                        zeros_ph2_i,
  output im2col_cfg_pkg::dim_t        n_zeros_left_o,
  output im2col_cfg_pkg::dim_t        n_zeros_right_o,
  output im2col_cfg_pkg::dim_t        n_zeros_top_o,
  output im2col_cfg_pkg::dim_t        n_zeros_bottom_o,
  output im2col_desc_pkg::xfer_size_t size_d1_o,
  output im2col_desc_pkg::xfer_size_t size_d2_o
);

  // distance from the filter tap to the right and bottom filter edge
  im2col_cfg_pkg::dim_t col_rem_q;
  im2col_cfg_pkg::dim_t row_rem_q;
  im2col_cfg_pkg::dim_t left_q;
  im2col_cfg_pkg::dim_t right_q;
  im2col_cfg_pkg::dim_t top_q;
  im2col_cfg_pkg::dim_t bottom_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      col_rem_q <= '0;
      row_rem_q <= '0;
      left_q    <= '0;
      right_q   <= '0;
      top_q     <= '0;
      bottom_q  <= '0;
    end else if (zeros_clear_i) begin
      col_rem_q <= '0;
      row_rem_q <= '0;
      left_q    <= '0;
      right_q   <= '0;
      top_q     <= '0;
      bottom_q  <= '0;
    end else if (zeros_ph1_i) begin
      col_rem_q <= cfg_i.fw - 1'b1 - w_offset_i;
      row_rem_q <= cfg_i.fh - 1'b1 - h_offset_i;
    end else if (zeros_ph2_i) begin
      left_q   <= (cfg_i.pad_left > w_offset_i) ? cfg_i.pad_left - w_offset_i : '0;
      top_q    <= (cfg_i.pad_top > h_offset_i) ? cfg_i.pad_top - h_offset_i : '0;
      right_q  <= (cfg_i.adpt_pad_right > col_rem_q) ? cfg_i.adpt_pad_right - col_rem_q : '0;
      bottom_q <= (cfg_i.adpt_pad_bottom > row_rem_q) ? cfg_i.adpt_pad_bottom - row_rem_q : '0;
    end
  end

  assign n_zeros_left_o   = left_q;
  assign n_zeros_right_o  = right_q;
  assign n_zeros_top_o    = top_q;
  assign n_zeros_bottom_o = bottom_q;

  // data elements actually read, the rest of the patch row or column is zero fill
  assign size_d1_o = cfg_i.n_patches_w - im2col_desc_pkg::xfer_size_t'(left_q)
                     - im2col_desc_pkg::xfer_size_t'(right_q);
  assign size_d2_o = cfg_i.n_patches_h - im2col_desc_pkg::xfer_size_t'(top_q)
                     - im2col_desc_pkg::xfer_size_t'(bottom_q);

endmodule

`default_nettype wire

// File: logic/im2col_loop_counters.sv
// loop counters of the im2col descriptor generator, walk batch and filter positions per channel
`timescale 1ns/1ns
`default_nettype none

module im2col_loop_counters (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  im2col_cfg_pkg::im2col_cfg_t cfg_i,
  input  logic                        cnt_clear_i,
  input  logic                        batch_inc_i,
  input  logic                        batch_clear_i,
  input  logic                        pos_step_i,
  output im2col_cfg_pkg::dim_t        w_offset_o,
  output im2col_cfg_pkg::dim_t        h_offset_o,
  output im2col_cfg_pkg::dim_t        im_c_o,
  output im2col_cfg_pkg::dim_t        batch_cnt_o,
  output logic                        batch_last_o,
  output logic                        pos_last_o
);

  im2col_cfg_pkg::dim_t w_off_q;
  im2col_cfg_pkg::dim_t h_off_q;
  im2col_cfg_pkg::dim_t im_c_q;
  im2col_cfg_pkg::dim_t batch_q;
  im2col_cfg_pkg::img_size_t pos_q;
  logic w_wrap;
  logic h_wrap;

  assign w_wrap = (w_off_q == cfg_i.fw - 1'b1);
  assign h_wrap = (h_off_q == cfg_i.fh - 1'b1);

  // innermost loop, one step per descriptor
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      batch_q <= '0;
    end else if (cnt_clear_i || batch_clear_i) begin
      batch_q <= '0;
    end else if (batch_inc_i) begin
      batch_q <= batch_q + 1'b1;
    end
  end

  // filter column, filter row, channel, stepped once all batches are done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_off_q <= '0;
      h_off_q <= '0;
      im_c_q  <= '0;
      pos_q   <= '0;
    end else if (cnt_clear_i) begin
      w_off_q <= '0;
      h_off_q <= '0;
      im_c_q  <= '0;
      pos_q   <= '0;
    end else if (pos_step_i) begin
      w_off_q <= w_wrap ? '0 : w_off_q + 1'b1;
      if (w_wrap) begin
        h_off_q <= h_wrap ? '0 : h_off_q + 1'b1;
      end
      // channel moves on after a full fh x fw window
      if (pos_last_o) begin
        im_c_q <= '0;
      end else if (w_wrap && h_wrap) begin
        im_c_q <= im_c_q + 1'b1;
      end
      pos_q <= pos_last_o ? '0 : pos_q + 1'b1;
    end
  end

  assign w_offset_o   = w_off_q;
  assign h_offset_o   = h_off_q;
  assign im_c_o       = im_c_q;
  assign batch_cnt_o  = batch_q;
  assign batch_last_o = (batch_q == cfg_i.batch - 1'b1);
  assign pos_last_o   = (pos_q == cfg_i.ch_col - 1'b1);

endmodule

`default_nettype wire

// File: logic/im2col_seq_fsm.sv
// sequencer FSM of the im2col descriptor generator, orders the compute phases and the FIFO push
`timescale 1ns/1ns
`default_nettype none

module im2col_seq_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic fifo_full_i,
  input  logic batch_last_i,
  input  logic pos_last_i,
  output logic fifo_push_o,
  output logic param_done_o,
  output logic cnt_clear_o,
  output logic batch_inc_o,
  output logic batch_clear_o,
  output logic pos_step_o,
  output logic zeros_clear_o,
  output logic zeros_ph1_o,
  output logic zeros_ph2_o,
  output logic out_ptr_clear_o,
  output logic out_ptr_step_o,
  output logic pipe_clear_o
);

  im2col_cfg_pkg::seq_state_e state_q;
  im2col_cfg_pkg::seq_state_e state_d;
  logic done_q;
  logic setup;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= im2col_cfg_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      im2col_cfg_pkg::IDLE: begin
        if (start_i) begin
          state_d = im2col_cfg_pkg::PRECOMP;
        end
      end
      im2col_cfg_pkg::PRECOMP: state_d = im2col_cfg_pkg::COND_EVAL;
      // last position was stepped past, nothing left to emit
      im2col_cfg_pkg::COND_EVAL: begin
        state_d = done_q ? im2col_cfg_pkg::IDLE : im2col_cfg_pkg::ZEROS_1;
      end
      im2col_cfg_pkg::ZEROS_1: state_d = im2col_cfg_pkg::ZEROS_2;
      im2col_cfg_pkg::ZEROS_2: state_d = im2col_cfg_pkg::INDEX_1;
      im2col_cfg_pkg::INDEX_1: state_d = im2col_cfg_pkg::INDEX_2;
      im2col_cfg_pkg::INDEX_2: state_d = im2col_cfg_pkg::INDEX_3;
      im2col_cfg_pkg::INDEX_3: begin
        if (!fifo_full_i) begin
          state_d = im2col_cfg_pkg::PUSH;
        end
      end
      // full may rise again right after INDEX_3, so the push waits here too
      im2col_cfg_pkg::PUSH: begin
        if (!fifo_full_i) begin
          state_d = im2col_cfg_pkg::OUT_PTR_UPDATE;
        end
      end
      im2col_cfg_pkg::OUT_PTR_UPDATE: begin
        if (batch_last_i) begin
          state_d = im2col_cfg_pkg::OFFSET_UPDATE;
        end else begin
          state_d = im2col_cfg_pkg::COND_EVAL;
        end
      end
      im2col_cfg_pkg::OFFSET_UPDATE: state_d = im2col_cfg_pkg::COND_EVAL;
      default: state_d = im2col_cfg_pkg::IDLE;
    endcase
  end

  // done is held through IDLE until the next start
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if ((state_q == im2col_cfg_pkg::IDLE) && start_i) begin
      done_q <= 1'b0;
    end else if ((state_q == im2col_cfg_pkg::OFFSET_UPDATE) && pos_last_i) begin
      done_q <= 1'b1;
    end
  end

  assign setup = (state_q == im2col_cfg_pkg::IDLE) || (state_q == im2col_cfg_pkg::PRECOMP);

  assign fifo_push_o     = (state_q == im2col_cfg_pkg::PUSH) && !fifo_full_i;
  assign param_done_o    = done_q;
  assign cnt_clear_o     = setup;
  assign zeros_clear_o   = setup;
  assign out_ptr_clear_o = setup;
  assign pipe_clear_o    = (state_q == im2col_cfg_pkg::IDLE);
  assign zeros_ph1_o     = (state_q == im2col_cfg_pkg::ZEROS_1);
  assign zeros_ph2_o     = (state_q == im2col_cfg_pkg::ZEROS_2);
  assign batch_inc_o     = (state_q == im2col_cfg_pkg::OUT_PTR_UPDATE);
  assign out_ptr_step_o  = (state_q == im2col_cfg_pkg::OUT_PTR_UPDATE);
  assign batch_clear_o   = (state_q == im2col_cfg_pkg::OFFSET_UPDATE);
  assign pos_step_o      = (state_q == im2col_cfg_pkg::OFFSET_UPDATE);

endmodule

`default_nettype wire

// File: logic/im2col_desc_pkg.sv
// DMA descriptor types pushed by the im2col descriptor generator into the FIFO
`default_nettype none

package im2col_desc_pkg;

`include "im2col_defs.svh"

  typedef logic [`IM2COL_PTR_W-1:0] ptr_t;
  typedef logic [`IM2COL_SIZE_W-1:0] xfer_size_t;
  typedef logic [`IM2COL_INC_W-1:0] inc_t;

  // one 2D transfer with zero padding on all four sides
  typedef struct packed {
    ptr_t input_ptr;
    ptr_t output_ptr;
    // added to the source pointer at the end of each row
    inc_t in_inc_d2;
    logic [`IM2COL_DIM_W-1:0] n_zeros_top;
    logic [`IM2COL_DIM_W-1:0] n_zeros_bottom;
    logic [`IM2COL_DIM_W-1:0] n_zeros_left;
    logic [`IM2COL_DIM_W-1:0] n_zeros_right;
    xfer_size_t size_d1;
    xfer_size_t size_d2;
  } dma_desc_t;

endpackage

`default_nettype wire

// File: logic/im2col_cfg_pkg.sv
// configuration and sequencer types of the im2col descriptor generator, used by scoped name
`default_nettype none

package im2col_cfg_pkg;

`include "im2col_defs.svh"

  typedef logic [`IM2COL_DIM_W-1:0] dim_t;
  typedef logic [`IM2COL_SIZE_W-1:0] img_size_t;
  typedef logic [`IM2COL_IDX_W-1:0] idx_t;

  // must stay stable from start until done
  typedef struct packed {
    logic [`IM2COL_PTR_W-1:0] src_ptr;
    logic [`IM2COL_PTR_W-1:0] dst_ptr;
    img_size_t ih;
    img_size_t iw;
    dim_t fh;
    dim_t fw;
    dim_t num_ch;
    dim_t batch;
    // num_ch * fh * fw
    img_size_t ch_col;
    dim_t pad_left;
    dim_t pad_top;
    dim_t adpt_pad_right;
    dim_t adpt_pad_bottom;
    img_size_t n_patches_w;
    img_size_t n_patches_h;
  } im2col_cfg_t;

  typedef enum logic [3:0] {
    IDLE,
    PRECOMP,
    COND_EVAL,
    ZEROS_1,
    ZEROS_2,
    INDEX_1,
    INDEX_2,
    INDEX_3,
    PUSH,
    OUT_PTR_UPDATE,
    OFFSET_UPDATE
  } seq_state_e;

endpackage

`default_nettype wire

// File: include/im2col_defs.svh
// width definitions for the im2col descriptor generator, included by its packages
`ifndef IM2COL_DEFS_SVH
`define IM2COL_DEFS_SVH

// filter, pad, channel and batch quantities
`define IM2COL_DIM_W 8

// image sizes and patch counts
`define IM2COL_SIZE_W 16

// byte addresses into system memory
`define IM2COL_PTR_W 32

// element index into the input tensor
`define IM2COL_IDX_W 32

// source row increment carried in the DMA descriptor
`define IM2COL_INC_W 23

`endif
